//--- rv32i_consts.svh
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

// Datapath word width
`define XLEN 32

// Architectural register index width
`define REG_IDX_W 5

`define ZERO_REG 0 // x0 is hardwired to zero

`endif

//--- pcmux.sv
package pcmux;

  // Next-PC source select
  typedef enum logic [1:0] {
    pc_plus4 = 2'b00,
    alu_out  = 2'b01,
    alu_mod2 = 2'b10
  } pcmux_sel_t;

endpackage

//--- rv32i_types.sv
`include "rv32i_consts.svh"

package rv32i_types;

  typedef logic [`XLEN-1:0] rv32i_word;
  typedef logic [`REG_IDX_W-1:0] rv32i_reg;

  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } rv32i_opcode;

  typedef enum logic [2:0] {
    alu_add = 3'b000,
    alu_sll = 3'b001,
    alu_sra = 3'b010,
    alu_sub = 3'b011,
    alu_xor = 3'b100,
    alu_srl = 3'b101,
    alu_or  = 3'b110,
    alu_and = 3'b111
  } alu_ops;

  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_funct3_t;

  // Store funct3 shares the lb/lh/lw encodings
  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } load_funct3_t;

  typedef struct packed {
    rv32i_opcode        opcode;
    alu_ops             aluop;
    branch_funct3_t     cmpop;
    pcmux::pcmux_sel_t  pcmux_sel;
    rv32i_reg           rd;
    logic               load_regfile;
    logic [2:0]         funct3;
  } rv32i_control_word;

endpackage

//--- alu.sv
`timescale 1ns/1ps

module alu (
  input  rv32i_types::alu_ops    aluop_i,
  input  rv32i_types::rv32i_word a_i,
  input  rv32i_types::rv32i_word b_i,
  output rv32i_types::rv32i_word f_o,
  output rv32i_types::rv32i_word jalr_target_o
);

  import rv32i_types::*;

  rv32i_word sum;

  assign sum = a_i + b_i;

  always_comb begin
    case (aluop_i)
      alu_add: f_o = sum;
      alu_sll: f_o = a_i << b_i[4:0];
      alu_sra: f_o = rv32i_word'($signed(a_i) >>> b_i[4:0]);
      alu_sub: f_o = a_i - b_i;
      alu_xor: f_o = a_i ^ b_i;
      alu_srl: f_o = a_i >> b_i[4:0];
      alu_or:  f_o = a_i | b_i;
      alu_and: f_o = a_i & b_i;
      default: f_o = sum;
    endcase
  end

  assign jalr_target_o = sum & ~rv32i_word'(1); // LSB cleared per spec

endmodule

//--- cmp.sv
`timescale 1ns/1ps

module cmp (
  input  rv32i_types::branch_funct3_t cmpop_i,
  input  rv32i_types::rv32i_opcode    opcode_i,
  input  rv32i_types::rv32i_word      a_i,
  input  rv32i_types::rv32i_word      b_i,
  output logic                        br_en_o
);

  import rv32i_types::*;

  logic cond;

  always_comb begin
    case (cmpop_i)
      beq:     cond = (a_i == b_i);
      bne:     cond = (a_i != b_i);
      blt:     cond = ($signed(a_i) < $signed(b_i));
      bge:     cond = ($signed(a_i) >= $signed(b_i));
      bltu:    cond = (a_i < b_i);
      bgeu:    cond = (a_i >= b_i);
      default: cond = 1'b0;
    endcase
  end

  assign br_en_o = cond && (opcode_i == op_br); // Only branches compare

endmodule

//--- ex_forward_unit.sv
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module ex_forward_unit (
  input  rv32i_types::rv32i_word         instr_i,
  input  rv32i_types::rv32i_control_word id_ex_i,
  input  rv32i_types::rv32i_control_word ex_mem_i,
  input  rv32i_types::rv32i_control_word mem_wb_i,
  output logic [1:0]                     fwd_a_o,
  output logic [1:0]                     fwd_b_o
);

  import rv32i_types::*;

  logic reads_rs1;
  logic reads_rs2;

  // 2 = EX/MEM, 1 = MEM/WB, 0 = register file operand
  function automatic logic [1:0] fwd_sel(input rv32i_reg src, input logic reads,
                                         input rv32i_control_word ex_mem,
                                         input rv32i_control_word mem_wb);
    if (!reads || src == rv32i_reg'(`ZERO_REG))
      return 2'd0;
    if (ex_mem.load_regfile && ex_mem.rd == src)
      return 2'd2; // Youngest result wins
    if (mem_wb.load_regfile && mem_wb.rd == src)
      return 2'd1;
    return 2'd0;
  endfunction

  assign reads_rs1 = id_ex_i.opcode inside {op_reg, op_imm, op_load, op_store, op_br, op_jalr};
  assign reads_rs2 = id_ex_i.opcode inside {op_reg, op_br};

  assign fwd_a_o = fwd_sel(instr_i[19:15], reads_rs1, ex_mem_i, mem_wb_i);
  assign fwd_b_o = fwd_sel(instr_i[24:20], reads_rs2, ex_mem_i, mem_wb_i);

  always_comb begin
    assert (fwd_a_o != 2'd3 && fwd_b_o != 2'd3)
      else $error("forward select 3 is undefined");
  end

endmodule

//--- instruction_execute.sv
`timescale 1ns/1ps

module instruction_execute (
  input  logic                           clk,
  input  logic                           rst,
  input  rv32i_types::rv32i_word         pc_i,
  input  rv32i_types::rv32i_word         instruction_i,
  input  rv32i_types::rv32i_word         alu_in_1_i,
  input  rv32i_types::rv32i_word         alu_in_2_i,
  input  rv32i_types::rv32i_word         rs1_i,
  input  rv32i_types::rv32i_word         rs2_i,
  input  rv32i_types::rv32i_word         cmp_in_i,
  input  rv32i_types::rv32i_control_word ctrl_word_i,
  input  logic                           ma_stall_i,
  input  rv32i_types::rv32i_control_word mem_wb_ctrl_i,
  input  rv32i_types::rv32i_word         mem_wb_data_i,
  output rv32i_types::rv32i_control_word ctrl_word_o,
  output rv32i_types::rv32i_word         instruction_o,
  output rv32i_types::rv32i_word         pc_o,
  output rv32i_types::rv32i_word         alu_out_o,
  output rv32i_types::rv32i_word         rs2_o,
  output logic                           br_en_o,
  output logic [3:0]                     mem_byte_enable_o,
  output rv32i_types::rv32i_word         alu_out_to_pc_o,
  output pcmux::pcmux_sel_t              pcmux_sel_o,
  output logic                           br_taken_o
);

  import rv32i_types::*;
  import pcmux::*;

  logic [1:0] fwd_a;
  logic [1:0] fwd_b;
  rv32i_word  alu_a;
  rv32i_word  alu_b;
  rv32i_word  cmp_a;
  rv32i_word  cmp_b;
  rv32i_word  alu_result;
  rv32i_word  jalr_target;
  logic       br_en;
  logic [3:0] byte_enable;

  function automatic rv32i_word fwd_mux(input logic [1:0] sel, input rv32i_word normal,
                                        input rv32i_word ex_mem, input rv32i_word mem_wb);
    case (sel)
      2'd2:    return ex_mem;
      2'd1:    return mem_wb;
      default: return normal;
    endcase
  endfunction

  ex_forward_unit fwd_unit (
    .instr_i  (instruction_i),
    .id_ex_i  (ctrl_word_i),
    .ex_mem_i (ctrl_word_o),
    .mem_wb_i (mem_wb_ctrl_i),
    .fwd_a_o  (fwd_a),
    .fwd_b_o  (fwd_b)
  );

  assign alu_a = fwd_mux(fwd_a, alu_in_1_i, alu_out_o, mem_wb_data_i);
  assign alu_b = fwd_mux(fwd_b, alu_in_2_i, alu_out_o, mem_wb_data_i);
  assign cmp_a = fwd_mux(fwd_a, rs1_i, alu_out_o, mem_wb_data_i);
  assign cmp_b = fwd_mux(fwd_b, cmp_in_i, alu_out_o, mem_wb_data_i);

  alu alu_u (
    .aluop_i       (ctrl_word_i.aluop),
    .a_i           (alu_a),
    .b_i           (alu_b),
    .f_o           (alu_result),
    .jalr_target_o (jalr_target)
  );

  cmp cmp_u (
    .cmpop_i  (ctrl_word_i.cmpop),
    .opcode_i (ctrl_word_i.opcode),
    .a_i      (cmp_a),
    .b_i      (cmp_b),
    .br_en_o  (br_en)
  );

  assign br_taken_o = br_en || ctrl_word_i.opcode inside {op_jal, op_jalr};
  assign pcmux_sel_o = br_taken_o ? ctrl_word_i.pcmux_sel : pc_plus4;
  // Non-jalr target is the unforwarded pc + imm sum
  assign alu_out_to_pc_o = (ctrl_word_i.opcode == op_jalr) ? jalr_target
                                                           : alu_in_1_i + alu_in_2_i;

  always_comb begin
    byte_enable = 4'b0000;
    if (ctrl_word_i.opcode inside {op_load, op_store}) begin
      case (load_funct3_t'(ctrl_word_i.funct3))
        lb, lbu: byte_enable = 4'b0001 << alu_result[1:0];
        lh, lhu: byte_enable = 4'b0011 << alu_result[1:0]; // Upper bytes drop off
        default: byte_enable = 4'b1111 << alu_result[1:0];
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_word_o       <= '0;
      instruction_o     <= '0;
      pc_o              <= '0;
      alu_out_o         <= '0;
      rs2_o             <= '0;
      br_en_o           <= 1'b0;
      mem_byte_enable_o <= 4'b0000;
    end else if (!ma_stall_i) begin
      ctrl_word_o       <= ctrl_word_i;
      instruction_o     <= instruction_i;
      pc_o              <= pc_i;
      alu_out_o         <= alu_result;
      rs2_o             <= rs2_i; // Store data
      br_en_o           <= br_en;
      mem_byte_enable_o <= byte_enable;
    end
  end

  assert property (@(posedge clk) (ma_stall_i && !rst) |=>
                   $stable(ctrl_word_o) && $stable(instruction_o) && $stable(pc_o) &&
                   $stable(alu_out_o) && $stable(rs2_o) && $stable(br_en_o) &&
                   $stable(mem_byte_enable_o))
    else $error("EX/MEM register changed under stall");

endmodule

//--- mem_wb_stage.sv
`timescale 1ns/1ps
`include "rv32i_consts.svh"

module mem_wb_stage (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           ma_stall_i,
  input  rv32i_types::rv32i_control_word ex_mem_ctrl_i,
  input  rv32i_types::rv32i_word         ex_mem_alu_i,
  input  rv32i_types::rv32i_word         ex_mem_pc_i,
  input  rv32i_types::rv32i_word         dmem_rdata_i,
  output rv32i_types::rv32i_control_word wb_ctrl_o,
  output rv32i_types::rv32i_word         wb_data_o
);

  import rv32i_types::*;

  rv32i_word shifted;
  rv32i_word load_val;
  rv32i_word wb_next;

  assign shifted = dmem_rdata_i >> {ex_mem_alu_i[1:0], 3'b000}; // Byte lane to bit 0

  always_comb begin
    case (load_funct3_t'(ex_mem_ctrl_i.funct3))
      lb:      load_val = {{(`XLEN-8){shifted[7]}}, shifted[7:0]};
      lbu:     load_val = {{(`XLEN-8){1'b0}}, shifted[7:0]};
      lh:      load_val = {{(`XLEN-16){shifted[15]}}, shifted[15:0]};
      lhu:     load_val = {{(`XLEN-16){1'b0}}, shifted[15:0]};
      default: load_val = shifted;
    endcase
  end

  always_comb begin
    case (ex_mem_ctrl_i.opcode)
      op_load:          wb_next = load_val;
      op_jal, op_jalr:  wb_next = ex_mem_pc_i + rv32i_word'(4); // Link address
      default:          wb_next = ex_mem_alu_i;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ctrl_o <= '0;
      wb_data_o <= '0;
    end else if (!ma_stall_i) begin
      wb_ctrl_o <= ex_mem_ctrl_i;
      wb_data_o <= wb_next;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
                   (!ma_stall_i && ex_mem_ctrl_i.opcode == op_load &&
                    ex_mem_ctrl_i.funct3 == lw) |-> (ex_mem_alu_i[1:0] == 2'b00))
    else $error("word load from unaligned address");

endmodule

//--- execute_top.sv
`timescale 1ns/1ps

module execute_top (
  input  logic                           clk,
  input  logic                           rst,
  input  rv32i_types::rv32i_word         pc_i,
  input  rv32i_types::rv32i_word         instruction_i,
  input  rv32i_types::rv32i_word         alu_in_1_i,
  input  rv32i_types::rv32i_word         alu_in_2_i,
  input  rv32i_types::rv32i_word         rs1_i,
  input  rv32i_types::rv32i_word         rs2_i,
  input  rv32i_types::rv32i_word         cmp_in_i,
  input  rv32i_types::rv32i_control_word ctrl_word_i,
  input  logic                           ma_stall_i,
  input  rv32i_types::rv32i_word         dmem_rdata_i,
  output rv32i_types::rv32i_control_word ex_mem_ctrl_o,
  output rv32i_types::rv32i_word         ex_mem_alu_o,
  output rv32i_types::rv32i_word         ex_mem_pc_o,
  output rv32i_types::rv32i_word         ex_mem_rs2_o,
  output rv32i_types::rv32i_word         ex_mem_instr_o,
  output logic                           ex_mem_br_en_o,
  output logic [3:0]                     mem_byte_enable_o,
  output rv32i_types::rv32i_word         alu_out_to_pc_o,
  output pcmux::pcmux_sel_t              pcmux_sel_o,
  output logic                           br_taken_o,
  output rv32i_types::rv32i_control_word wb_ctrl_o,
  output rv32i_types::rv32i_word         wb_data_o
);

  instruction_execute ex_stage (
    .clk               (clk),
    .rst               (rst),
    .pc_i              (pc_i),
    .instruction_i     (instruction_i),
    .alu_in_1_i        (alu_in_1_i),
    .alu_in_2_i        (alu_in_2_i),
    .rs1_i             (rs1_i),
    .rs2_i             (rs2_i),
    .cmp_in_i          (cmp_in_i),
    .ctrl_word_i       (ctrl_word_i),
    .ma_stall_i        (ma_stall_i),
    .mem_wb_ctrl_i     (wb_ctrl_o), // MEM/WB forwarding source
    .mem_wb_data_i     (wb_data_o),
    .ctrl_word_o       (ex_mem_ctrl_o),
    .instruction_o     (ex_mem_instr_o),
    .pc_o              (ex_mem_pc_o),
    .alu_out_o         (ex_mem_alu_o),
    .rs2_o             (ex_mem_rs2_o),
    .br_en_o           (ex_mem_br_en_o),
    .mem_byte_enable_o (mem_byte_enable_o),
    .alu_out_to_pc_o   (alu_out_to_pc_o),
    .pcmux_sel_o       (pcmux_sel_o),
    .br_taken_o        (br_taken_o)
  );

  mem_wb_stage wb_stage (
    .clk           (clk),
    .rst           (rst),
    .ma_stall_i    (ma_stall_i),
    .ex_mem_ctrl_i (ex_mem_ctrl_o),
    .ex_mem_alu_i  (ex_mem_alu_o),
    .ex_mem_pc_i   (ex_mem_pc_o),
    .dmem_rdata_i  (dmem_rdata_i),
    .wb_ctrl_o     (wb_ctrl_o),
    .wb_data_o     (wb_data_o)
  );

endmodule

//--- tb_execute_top.sv
`timescale 1ns/1ps

module tb_execute_top;

  import rv32i_types::*;
  import pcmux::*;

  typedef struct packed {
    rv32i_control_word ctrl;
    rv32i_word         instr, pc, alu, rs2, target;
    logic              br_en, taken;
    pcmux_sel_t        sel;
    logic [3:0]        be;
    logic              valid;
  } ex_t;

  typedef struct packed {
    rv32i_control_word ctrl;
    rv32i_word         data;
    logic              valid;
  } wb_t;

  logic clk;
  logic rst;
  logic ma_stall_i;
  logic in_valid;
  rv32i_word pc_i, instruction_i, alu_in_1_i, alu_in_2_i, rs1_i, rs2_i, cmp_in_i, dmem_rdata_i;
  rv32i_control_word ctrl_word_i;
  rv32i_control_word ex_mem_ctrl_o, wb_ctrl_o;
  rv32i_word ex_mem_alu_o, ex_mem_pc_o, ex_mem_rs2_o, ex_mem_instr_o, alu_out_to_pc_o, wb_data_o;
  logic ex_mem_br_en_o, br_taken_o;
  logic [3:0] mem_byte_enable_o;
  pcmux_sel_t pcmux_sel_o;

  ex_t ex_q;
  wb_t wb_q;
  ex_t cur;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int failed = 0;
  int test_err_base = 0;

  execute_top dut_i (
    .clk               (clk),
    .rst               (rst),
    .pc_i              (pc_i),
    .instruction_i     (instruction_i),
    .alu_in_1_i        (alu_in_1_i),
    .alu_in_2_i        (alu_in_2_i),
    .rs1_i             (rs1_i),
    .rs2_i             (rs2_i),
    .cmp_in_i          (cmp_in_i),
    .ctrl_word_i       (ctrl_word_i),
    .ma_stall_i        (ma_stall_i),
    .dmem_rdata_i      (dmem_rdata_i),
    .ex_mem_ctrl_o     (ex_mem_ctrl_o),
    .ex_mem_alu_o      (ex_mem_alu_o),
    .ex_mem_pc_o       (ex_mem_pc_o),
    .ex_mem_rs2_o      (ex_mem_rs2_o),
    .ex_mem_instr_o    (ex_mem_instr_o),
    .ex_mem_br_en_o    (ex_mem_br_en_o),
    .mem_byte_enable_o (mem_byte_enable_o),
    .alu_out_to_pc_o   (alu_out_to_pc_o),
    .pcmux_sel_o       (pcmux_sel_o),
    .br_taken_o        (br_taken_o),
    .wb_ctrl_o         (wb_ctrl_o),
    .wb_data_o         (wb_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic rv32i_word alu_ref(input alu_ops op, input rv32i_word a, input rv32i_word b);
    logic [63:0] ext;
    ext = {{32{a[31]}}, a} >> b[4:0]; // Sign bits shift in from above
    case (op)
      alu_add: return a + b;
      alu_sub: return a + ~b + 32'd1;
      alu_sll: return a << b[4:0];
      alu_srl: return a >> b[4:0];
      alu_sra: return ext[31:0];
      alu_xor: return a ^ b;
      alu_or:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic cmp_ref(input logic [2:0] f3, input rv32i_word a, input rv32i_word b);
    rv32i_word sa;
    rv32i_word sb;
    sa = a ^ 32'h8000_0000; // Bias for signed order
    sb = b ^ 32'h8000_0000;
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return sa < sb;
      3'b101:  return sa >= sb;
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [3:0] be_ref(input rv32i_opcode op, input logic [2:0] f3,
                                        input logic [1:0] off);
    if (op != op_load && op != op_store)
      return 4'b0000;
    case (f3[1:0])
      2'b00:   return 4'b0001 << off;
      2'b01:   return (off == 2'd0) ? 4'b0011 : (off == 2'd1) ? 4'b0110 :
                      (off == 2'd2) ? 4'b1100 : 4'b1000;
      default: return (off == 2'd0) ? 4'b1111 : (off == 2'd1) ? 4'b1110 :
                      (off == 2'd2) ? 4'b1100 : 4'b1000;
    endcase
  endfunction

  // Forwarded source value from the shadow pipeline
  function automatic rv32i_word pick(input rv32i_reg s, input logic reads, input rv32i_word normal,
                                     input ex_t ex, input wb_t wb);
    if (!reads || s == 5'd0)
      return normal;
    if (ex.ctrl.load_regfile && ex.ctrl.rd == s)
      return ex.alu;
    if (wb.ctrl.load_regfile && wb.ctrl.rd == s)
      return wb.data;
    return normal;
  endfunction

  function automatic ex_t ref_execute(input ex_t ex, input wb_t wb);
    ex_t r;
    logic reads1;
    logic reads2;
    rv32i_word a;
    rv32i_word b;
    r = '0;
    reads1 = ctrl_word_i.opcode inside {op_reg, op_imm, op_load, op_store, op_br, op_jalr};
    reads2 = ctrl_word_i.opcode inside {op_reg, op_br};
    a = pick(instruction_i[19:15], reads1, alu_in_1_i, ex, wb);
    b = pick(instruction_i[24:20], reads2, alu_in_2_i, ex, wb);
    r.br_en = (ctrl_word_i.opcode == op_br) &&
              cmp_ref(ctrl_word_i.cmpop, pick(instruction_i[19:15], reads1, rs1_i, ex, wb),
                      pick(instruction_i[24:20], reads2, cmp_in_i, ex, wb));
    r.taken = r.br_en || ctrl_word_i.opcode == op_jal || ctrl_word_i.opcode == op_jalr;
    r.sel = r.taken ? ctrl_word_i.pcmux_sel : pc_plus4;
    r.target = (ctrl_word_i.opcode == op_jalr) ? ((a + b) & 32'hffff_fffe)
                                               : alu_in_1_i + alu_in_2_i;
    r.alu = alu_ref(ctrl_word_i.aluop, a, b);
    r.be = be_ref(ctrl_word_i.opcode, ctrl_word_i.funct3, r.alu[1:0]);
    r.ctrl = ctrl_word_i;
    r.instr = instruction_i;
    r.pc = pc_i;
    r.rs2 = rs2_i;
    r.valid = in_valid;
    return r;
  endfunction

  function automatic rv32i_word wb_ref(input ex_t ex, input rv32i_word rdata);
    rv32i_word s;
    s = rdata >> (8 * int'(ex.alu[1:0]));
    if (ex.ctrl.opcode == op_jal || ex.ctrl.opcode == op_jalr)
      return ex.pc + 32'd4;
    if (ex.ctrl.opcode != op_load)
      return ex.alu;
    case (ex.ctrl.funct3)
      3'b000:  return 32'($signed(s[7:0]));
      3'b100:  return 32'(s[7:0]);
      3'b001:  return 32'($signed(s[15:0]));
      3'b101:  return 32'(s[15:0]);
      default: return s;
    endcase
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("MISMATCH t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      ex_q = '0;
      wb_q = '0;
    end else begin
      cur = ref_execute(ex_q, wb_q);
      check("br_taken_o", 64'(br_taken_o), 64'(cur.taken));
      check("pcmux_sel_o", 64'(pcmux_sel_o), 64'(cur.sel));
      check("alu_out_to_pc_o", 64'(alu_out_to_pc_o), 64'(cur.target));
      check("ex_mem_ctrl_o", 64'(ex_mem_ctrl_o), 64'(ex_q.ctrl));
      check("ex_mem_alu_o", 64'(ex_mem_alu_o), 64'(ex_q.alu));
      check("ex_mem_pc_o", 64'(ex_mem_pc_o), 64'(ex_q.pc));
      check("ex_mem_rs2_o", 64'(ex_mem_rs2_o), 64'(ex_q.rs2));
      check("ex_mem_instr_o", 64'(ex_mem_instr_o), 64'(ex_q.instr));
      check("ex_mem_br_en_o", 64'(ex_mem_br_en_o), 64'(ex_q.br_en));
      check("mem_byte_enable_o", 64'(mem_byte_enable_o), 64'(ex_q.be));
      check("wb_ctrl_o", 64'(wb_ctrl_o), 64'(wb_q.ctrl));
      check("wb_data_o", 64'(wb_data_o), 64'(wb_q.data));
      if (!ma_stall_i) begin
        wb_q.ctrl = ex_q.ctrl;
        wb_q.data = wb_ref(ex_q, dmem_rdata_i); // Read data arrives with the address
        wb_q.valid = ex_q.valid;
        ex_q = cur;
      end
    end
  end

  function automatic rv32i_control_word make_ctrl(input rv32i_opcode op, input alu_ops aop,
                                                  input logic [2:0] f3, input pcmux_sel_t sel,
                                                  input int rd, input logic lrf);
    rv32i_control_word c;
    c.opcode = op;
    c.aluop = aop;
    c.cmpop = branch_funct3_t'(f3);
    c.pcmux_sel = sel;
    c.rd = rv32i_reg'(rd);
    c.load_regfile = lrf;
    c.funct3 = f3;
    return c;
  endfunction

  function automatic rv32i_word make_instr(input rv32i_opcode op, input int rd,
                                           input logic [2:0] f3, input int rs1, input int rs2);
    return {7'b0, rv32i_reg'(rs2), rv32i_reg'(rs1), f3, rv32i_reg'(rd), op};
  endfunction

  task automatic idle_inputs();
    ctrl_word_i = '0;
    instruction_i = '0;
    pc_i = '0;
    alu_in_1_i = '0;
    alu_in_2_i = '0;
    rs1_i = '0;
    rs2_i = '0;
    cmp_in_i = '0;
    in_valid = 1'b0;
  endtask

  // Holds one instruction on the inputs until it is captured
  task automatic present(input rv32i_control_word c, input rv32i_word instr, input rv32i_word pc,
                         input rv32i_word a1, input rv32i_word a2, input rv32i_word v1,
                         input rv32i_word v2, input rv32i_word cin, input int stall_n);
    ctrl_word_i = c;
    instruction_i = instr;
    pc_i = pc;
    alu_in_1_i = a1;
    alu_in_2_i = a2;
    rs1_i = v1;
    rs2_i = v2;
    cmp_in_i = cin;
    in_valid = 1'b1;
    ma_stall_i = (stall_n > 0);
    dmem_rdata_i = $urandom;
    repeat (stall_n) begin
      @(negedge clk);
      dmem_rdata_i = $urandom;
    end
    ma_stall_i = 1'b0;
    @(negedge clk);
  endtask

  task automatic issue_alu(input rv32i_opcode op, input alu_ops aop, input int rd, input int rs1,
                           input int rs2, input int stall_n);
    rv32i_word v1;
    rv32i_word v2;
    v1 = $urandom;
    v2 = $urandom;
    present(make_ctrl(op, aop, 3'b000, pc_plus4, rd, 1'b1), make_instr(op, rd, 3'b000, rs1, rs2),
            $urandom & ~32'h3, v1, (op == op_imm) ? 32'($signed(12'($urandom))) : v2,
            v1, v2, v2, stall_n);
  endtask

  task automatic issue_branch(input logic [2:0] f3, input int rs1, input int rs2,
                              input rv32i_word v1, input rv32i_word v2);
    rv32i_word pc;
    pc = $urandom & ~32'h3;
    present(make_ctrl(op_br, alu_add, f3, alu_out, 0, 1'b0), make_instr(op_br, 0, f3, rs1, rs2),
            pc, pc, $urandom & 32'h0000_0ffe, v1, v2, v2, 0);
  endtask

  task automatic issue_jump(input rv32i_opcode op, input int rd, input int rs1);
    rv32i_word pc;
    rv32i_word v1;
    pc = $urandom & ~32'h3;
    v1 = $urandom;
    present(make_ctrl(op, alu_add, 3'b000, (op == op_jalr) ? alu_mod2 : alu_out, rd, 1'b1),
            make_instr(op, rd, 3'b000, rs1, 0), pc, (op == op_jalr) ? v1 : pc,
            $urandom & 32'h0000_0fff, v1, 32'd0, 32'd0, 0);
  endtask

  task automatic issue_mem(input rv32i_opcode op, input logic [2:0] f3, input int off,
                           input int stall_n);
    rv32i_word base;
    int rd;
    base = $urandom & ~32'h3;
    rd = (op == op_load) ? 16 + int'($urandom % 16) : 0;
    present(make_ctrl(op, alu_add, f3, pc_plus4, rd, op == op_load),
            make_instr(op, rd, f3, 2, 3), $urandom & ~32'h3, base, 32'(off), base,
            $urandom, 32'd0, stall_n);
  endtask

  task automatic drain();
    int n;
    n = 0;
    idle_inputs();
    while ((ex_q.valid || wb_q.valid) && n < 20) begin
      @(negedge clk);
      dmem_rdata_i = $urandom;
      n++;
    end
    if (ex_q.valid || wb_q.valid) begin
      $display("Timeout: pipeline still busy after 20 idle cycles at t=%0t", $time);
      $display("TB FAILED");
      $finish;
    end
  endtask

  task automatic finish_test(input string name);
    drain();
    tests++;
    if (errors != test_err_base) begin
      failed++;
      $display("test %-10s FAIL (%0d errors)", name, errors - test_err_base);
    end else begin
      $display("test %-10s ok", name);
    end
    test_err_base = errors;
  endtask

  initial begin
    int i;
    logic [2:0] f3;
    rv32i_word v1;
    void'($urandom(32'h2edde698));
    rst = 1'b1;
    ma_stall_i = 1'b0;
    idle_inputs();
    // Live word load on the inputs while reset is held
    ctrl_word_i = make_ctrl(op_load, alu_add, 3'b010, pc_plus4, 17, 1'b1);
    instruction_i = make_instr(op_load, 17, 3'b010, 2, 3);
    pc_i = $urandom & ~32'h3;
    alu_in_1_i = ($urandom & ~32'h3) | 32'h100;
    rs1_i = alu_in_1_i;
    rs2_i = $urandom;
    dmem_rdata_i = $urandom;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    idle_inputs();

    @(negedge clk); // First edge out of reset compares against zero
    finish_test("reset");

    for (i = 0; i < 24; i++)
      issue_alu(($urandom % 2 == 0) ? op_reg : op_imm, alu_ops'(3'($urandom % 8)),
                16 + int'($urandom % 16), 1 + int'($urandom % 15), 1 + int'($urandom % 15), 0);
    finish_test("alu");

    for (i = 0; i < 12; i++) begin
      f3 = 3'(i % 6);
      if (f3 >= 3'd2)
        f3 = f3 + 3'd2; // Skip the unused encodings
      v1 = $urandom;
      issue_branch(f3, 3, 4, v1, (i < 6) ? v1 : $urandom);
    end
    for (i = 0; i < 3; i++) begin
      issue_jump(op_jal, 20, 0);
      issue_jump(op_jalr, 21, 5);
    end
    finish_test("branch");

    issue_alu(op_reg, alu_add, 5, 1, 2, 0);
    issue_alu(op_reg, alu_sub, 6, 5, 5, 0);  // Both sources from EX/MEM
    issue_alu(op_reg, alu_xor, 8, 7, 5, 0);  // rs2 from MEM/WB
    issue_alu(op_imm, alu_add, 9, 6, 0, 0);
    issue_alu(op_reg, alu_or, 9, 1, 2, 0);
    issue_alu(op_reg, alu_and, 9, 3, 4, 0);
    issue_alu(op_reg, alu_add, 11, 9, 9, 0); // Both stages hold x9
    issue_alu(op_reg, alu_add, 0, 1, 2, 0);
    issue_alu(op_reg, alu_sll, 12, 0, 0, 0); // x0 stays unforwarded
    issue_branch(3'b000, 12, 9, $urandom, $urandom);
    finish_test("forward");

    for (i = 0; i < 20; i++) begin
      f3 = 3'(i / 4);
      if (f3 > 3'd2)
        f3 = f3 + 3'd1;
      if (f3 != 3'b010 || i % 4 == 0)
        issue_mem(op_load, f3, i % 4, 0);
    end
    for (i = 0; i < 12; i++)
      issue_mem(op_store, 3'(i / 4), i % 4, 0);
    finish_test("load_store");

    for (i = 0; i < 4; i++) begin
      issue_alu(op_reg, alu_add, 16 + i, 1, 2, 0);
      issue_alu(op_reg, alu_sub, 20 + i, 16 + i, 1 + i, 1 + int'($urandom % 6));
      issue_mem(op_load, 3'b100, i, 1 + int'($urandom % 6));
    end
    finish_test("stall");

    $display("tests=%0d failed=%0d checks=%0d errors=%0d", tests, failed, checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

//--- execute_top.f
+incdir+.
pcmux.sv
rv32i_types.sv
alu.sv
cmp.sv
ex_forward_unit.sv
instruction_execute.sv
mem_wb_stage.sv
execute_top.sv
tb_execute_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f execute_top.f \
  --top-module tb_execute_top --Mdir obj_dir -o tb_execute_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_execute_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
  exit 1
fi
exit 0
